/* hw/mips_id_pkg.sv */
package mips_id_pkg;

	// datapath widths
	localparam int WORD_W = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// instruction field layout
	localparam int OPCODE_W = 6;
	localparam int OPCODE_POS = 26;
	localparam int RS_POS = 21;
	localparam int RT_POS = 16;
	localparam int RD_POS = 11;
	localparam int SHAMT_POS = 6;
	localparam int IMM_W = 16;
	localparam int JIDX_W = 26;

	// r0 reads as zero, r31 takes the return address
	localparam reg_addr_t NOP_REG = 5'd0;
	localparam reg_addr_t LINK_REG = 5'd31;

	// primary opcodes
	localparam logic [OPCODE_W-1:0]
		OPCODE_SPECIAL = 6'b000000, OPCODE_REGIMM = 6'b000001,
		OPCODE_J = 6'b000010, OPCODE_JAL = 6'b000011,
		OPCODE_BEQ = 6'b000100, OPCODE_BNE = 6'b000101,
		OPCODE_BLEZ = 6'b000110, OPCODE_BGTZ = 6'b000111,
		OPCODE_ADDI = 6'b001000, OPCODE_ADDIU = 6'b001001,
		OPCODE_SLTI = 6'b001010, OPCODE_SLTIU = 6'b001011,
		OPCODE_ANDI = 6'b001100, OPCODE_ORI = 6'b001101,
		OPCODE_XORI = 6'b001110, OPCODE_LUI = 6'b001111,
		OPCODE_LB = 6'b100000, OPCODE_LH = 6'b100001,
		OPCODE_LW = 6'b100011, OPCODE_LBU = 6'b100100,
		OPCODE_LHU = 6'b100101, OPCODE_SB = 6'b101000,
		OPCODE_SH = 6'b101001, OPCODE_SW = 6'b101011;

	// function codes under SPECIAL
	localparam logic [OPCODE_W-1:0]
		FUNCT_SLL = 6'b000000, FUNCT_SRL = 6'b000010, FUNCT_SRA = 6'b000011,
		FUNCT_SLLV = 6'b000100, FUNCT_SRLV = 6'b000110, FUNCT_SRAV = 6'b000111,
		FUNCT_JR = 6'b001000, FUNCT_JALR = 6'b001001,
		FUNCT_ADD = 6'b100000, FUNCT_ADDU = 6'b100001,
		FUNCT_SUB = 6'b100010, FUNCT_SUBU = 6'b100011,
		FUNCT_AND = 6'b100100, FUNCT_OR = 6'b100101,
		FUNCT_XOR = 6'b100110, FUNCT_NOR = 6'b100111,
		FUNCT_SLT = 6'b101010, FUNCT_SLTU = 6'b101011;

	// rt field codes under REGIMM
	localparam reg_addr_t
		REGIMM_BLTZ = 5'b00000, REGIMM_BGEZ = 5'b00001,
		REGIMM_BLTZAL = 5'b10000, REGIMM_BGEZAL = 5'b10001;

	// operation handed to EX
	typedef enum logic [7:0] {
		ALU_NOP = 8'b0000_0000, ALU_OR = 8'b0010_0101, ALU_AND = 8'b0010_0100,
		ALU_XOR = 8'b0010_0110, ALU_NOR = 8'b0010_0111, ALU_SLL = 8'b0111_1100,
		ALU_SRL = 8'b0000_0010, ALU_SRA = 8'b0000_0011, ALU_ADD = 8'b0010_0000,
		ALU_ADDU = 8'b0010_0001, ALU_ADDI = 8'b0101_0101, ALU_ADDIU = 8'b0101_0110,
		ALU_SUB = 8'b0010_0010, ALU_SUBU = 8'b0010_0011, ALU_SLT = 8'b0010_1010,
		ALU_SLTU = 8'b0010_1011, ALU_LB = 8'b1110_0000, ALU_LBU = 8'b1110_0100,
		ALU_LH = 8'b1110_0001, ALU_LHU = 8'b1110_0101, ALU_LW = 8'b1110_0011,
		ALU_SB = 8'b1110_1000, ALU_SH = 8'b1110_1001, ALU_SW = 8'b1110_1011,
		ALU_J = 8'b0100_1111, ALU_JAL = 8'b0101_0000, ALU_JR = 8'b0000_1000,
		ALU_JALR = 8'b0000_1001, ALU_BEQ = 8'b0101_0001, ALU_BNE = 8'b0101_0010,
		ALU_BGTZ = 8'b0101_0100, ALU_BLEZ = 8'b0101_0011, ALU_BGEZ = 8'b0100_0001,
		ALU_BLTZ = 8'b0100_0000, ALU_BGEZAL = 8'b0100_1011, ALU_BLTZAL = 8'b0100_1010
	} aluop_t;

	// result class, picks the EX result mux
	typedef enum logic [2:0] {
		SEL_NOP = 3'b000, SEL_LOGIC = 3'b001, SEL_SHIFT = 3'b010,
		SEL_ARITH = 3'b100, SEL_JUMP_BRANCH = 3'b110, SEL_LOAD_STORE = 3'b111
	} alusel_t;

	typedef enum logic [3:0] {
		BR_NONE, BR_JUMP_IMM, BR_JUMP_REG, BR_EQ, BR_NE,
		BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ
	} branch_kind_t;

endpackage

/* hw/id_bus_if.sv */
`timescale 1ns/100ps

// decoded control of the instruction sitting in ID
interface id_decode_if;
	mips_id_pkg::aluop_t aluop;
	mips_id_pkg::alusel_t alusel;
	logic wreg;
	mips_id_pkg::reg_addr_t wd;
	logic reg1_read;
	logic reg2_read;
	mips_id_pkg::reg_addr_t reg1_addr;
	mips_id_pkg::reg_addr_t reg2_addr;
	// also carries the pre-shifted branch offset or jump index
	mips_id_pkg::word_t imm;
	mips_id_pkg::branch_kind_t branch_kind;
	logic link;

	modport decoder (
		output aluop, alusel, wreg, wd, reg1_read, reg2_read,
		output reg1_addr, reg2_addr, imm, branch_kind, link
	);
	modport operand (input reg1_read, reg2_read, reg1_addr, reg2_addr, imm);
	modport branch (input branch_kind, link, imm);
	modport pipe (input aluop, alusel, wreg, wd);
endinterface

// writeback info of the instructions now in EX and MEM
interface id_fwd_if;
	logic ex_wreg;
	mips_id_pkg::reg_addr_t ex_wd;
	mips_id_pkg::word_t ex_wdata;
	mips_id_pkg::aluop_t ex_aluop;
	logic mem_wreg;
	mips_id_pkg::reg_addr_t mem_wd;
	mips_id_pkg::word_t mem_wdata;

	modport mux (input ex_wreg, ex_wd, ex_wdata, ex_aluop, mem_wreg, mem_wd, mem_wdata);
endinterface

/* hw/id_decoder.sv */
`timescale 1ns/100ps

module id_decoder (
	input  mips_id_pkg::word_t inst_i,
	id_decode_if.decoder       dec
);

	// raw fields
	logic [mips_id_pkg::OPCODE_W-1:0] opcode;
	logic [mips_id_pkg::OPCODE_W-1:0] funct;
	mips_id_pkg::reg_addr_t rs;
	mips_id_pkg::reg_addr_t rt;
	mips_id_pkg::reg_addr_t rd;
	mips_id_pkg::reg_addr_t shamt;
	logic [mips_id_pkg::IMM_W-1:0] imm16;
	// immediate forms
	mips_id_pkg::word_t imm_sext;
	mips_id_pkg::word_t imm_zext;
	mips_id_pkg::word_t imm_upper;
	mips_id_pkg::word_t imm_boff;
	mips_id_pkg::word_t imm_jidx;
	mips_id_pkg::aluop_t op;

	assign opcode = inst_i[mips_id_pkg::OPCODE_POS +: mips_id_pkg::OPCODE_W];
	assign funct = inst_i[mips_id_pkg::OPCODE_W-1:0];
	assign rs = inst_i[mips_id_pkg::RS_POS +: mips_id_pkg::REG_ADDR_W];
	assign rt = inst_i[mips_id_pkg::RT_POS +: mips_id_pkg::REG_ADDR_W];
	assign rd = inst_i[mips_id_pkg::RD_POS +: mips_id_pkg::REG_ADDR_W];
	assign shamt = inst_i[mips_id_pkg::SHAMT_POS +: mips_id_pkg::REG_ADDR_W];
	assign imm16 = inst_i[mips_id_pkg::IMM_W-1:0];

	assign imm_sext = {{(mips_id_pkg::WORD_W-mips_id_pkg::IMM_W){imm16[mips_id_pkg::IMM_W-1]}}, imm16};
	assign imm_zext = {{(mips_id_pkg::WORD_W-mips_id_pkg::IMM_W){1'b0}}, imm16};
	// lui lands in the upper half, then ORs with r0
	assign imm_upper = {imm16, {(mips_id_pkg::WORD_W-mips_id_pkg::IMM_W){1'b0}}};
	// word offset to byte offset
	assign imm_boff = {imm_sext[mips_id_pkg::WORD_W-3:0], 2'b00};
	// top nibble comes from pc+4 in the branch unit
	assign imm_jidx = {4'b0000, inst_i[mips_id_pkg::JIDX_W-1:0], 2'b00};

	always_comb begin
		// I-type defaults: rs read, rt written, signed imm
		op = mips_id_pkg::ALU_NOP;
		dec.wreg = 1'b1;
		dec.wd = rt;
		dec.reg1_read = 1'b1;
		dec.reg2_read = 1'b0;
		dec.reg1_addr = rs;
		dec.reg2_addr = rt;
		dec.imm = imm_sext;
		case (opcode)
			mips_id_pkg::OPCODE_SPECIAL: begin
				dec.wd = rd;
				dec.reg2_read = 1'b1;
				dec.imm = '0;
				case (funct)
					mips_id_pkg::FUNCT_AND: op = mips_id_pkg::ALU_AND;
					mips_id_pkg::FUNCT_OR: op = mips_id_pkg::ALU_OR;
					mips_id_pkg::FUNCT_XOR: op = mips_id_pkg::ALU_XOR;
					mips_id_pkg::FUNCT_NOR: op = mips_id_pkg::ALU_NOR;
					mips_id_pkg::FUNCT_SLL, mips_id_pkg::FUNCT_SLLV: op = mips_id_pkg::ALU_SLL;
					mips_id_pkg::FUNCT_SRL, mips_id_pkg::FUNCT_SRLV: op = mips_id_pkg::ALU_SRL;
					mips_id_pkg::FUNCT_SRA, mips_id_pkg::FUNCT_SRAV: op = mips_id_pkg::ALU_SRA;
					mips_id_pkg::FUNCT_ADD: op = mips_id_pkg::ALU_ADD;
					mips_id_pkg::FUNCT_ADDU: op = mips_id_pkg::ALU_ADDU;
					mips_id_pkg::FUNCT_SUB: op = mips_id_pkg::ALU_SUB;
					mips_id_pkg::FUNCT_SUBU: op = mips_id_pkg::ALU_SUBU;
					mips_id_pkg::FUNCT_SLT: op = mips_id_pkg::ALU_SLT;
					mips_id_pkg::FUNCT_SLTU: op = mips_id_pkg::ALU_SLTU;
					mips_id_pkg::FUNCT_JR: op = mips_id_pkg::ALU_JR;
					mips_id_pkg::FUNCT_JALR: op = mips_id_pkg::ALU_JALR;
					default: op = mips_id_pkg::ALU_NOP;
				endcase
				if (funct == mips_id_pkg::FUNCT_SLL || funct == mips_id_pkg::FUNCT_SRL ||
						funct == mips_id_pkg::FUNCT_SRA) begin
					// shift by shamt, rt is the only source and rs must be zero
					dec.reg1_read = 1'b0;
					dec.imm = {{(mips_id_pkg::WORD_W-mips_id_pkg::REG_ADDR_W){1'b0}}, shamt};
					if (rs != mips_id_pkg::NOP_REG)
						op = mips_id_pkg::ALU_NOP;
				end else if (shamt != '0) begin
					op = mips_id_pkg::ALU_NOP;
				end
				if (funct == mips_id_pkg::FUNCT_JR || funct == mips_id_pkg::FUNCT_JALR) begin
					dec.reg2_read = 1'b0;
					// jalr to r0 would drop the link anyway
					dec.wreg = (funct == mips_id_pkg::FUNCT_JALR) && (rd != mips_id_pkg::NOP_REG);
				end
			end
			mips_id_pkg::OPCODE_ANDI: begin
				op = mips_id_pkg::ALU_AND;
				dec.imm = imm_zext;
			end
			mips_id_pkg::OPCODE_ORI: begin
				op = mips_id_pkg::ALU_OR;
				dec.imm = imm_zext;
			end
			mips_id_pkg::OPCODE_XORI: begin
				op = mips_id_pkg::ALU_XOR;
				dec.imm = imm_zext;
			end
			mips_id_pkg::OPCODE_LUI: begin
				op = mips_id_pkg::ALU_OR;
				dec.imm = imm_upper;
			end
			mips_id_pkg::OPCODE_ADDI: op = mips_id_pkg::ALU_ADDI;
			mips_id_pkg::OPCODE_ADDIU: op = mips_id_pkg::ALU_ADDIU;
			mips_id_pkg::OPCODE_SLTI: op = mips_id_pkg::ALU_SLT;
			mips_id_pkg::OPCODE_SLTIU: op = mips_id_pkg::ALU_SLTU;
			mips_id_pkg::OPCODE_LB: op = mips_id_pkg::ALU_LB;
			mips_id_pkg::OPCODE_LBU: op = mips_id_pkg::ALU_LBU;
			mips_id_pkg::OPCODE_LH: op = mips_id_pkg::ALU_LH;
			mips_id_pkg::OPCODE_LHU: op = mips_id_pkg::ALU_LHU;
			mips_id_pkg::OPCODE_LW: op = mips_id_pkg::ALU_LW;
			mips_id_pkg::OPCODE_SB, mips_id_pkg::OPCODE_SH, mips_id_pkg::OPCODE_SW: begin
				// base in rs, store data in rt
				op = (opcode == mips_id_pkg::OPCODE_SB) ? mips_id_pkg::ALU_SB :
					(opcode == mips_id_pkg::OPCODE_SH) ? mips_id_pkg::ALU_SH : mips_id_pkg::ALU_SW;
				dec.wreg = 1'b0;
				dec.reg2_read = 1'b1;
			end
			mips_id_pkg::OPCODE_J, mips_id_pkg::OPCODE_JAL: begin
				op = (opcode == mips_id_pkg::OPCODE_J) ? mips_id_pkg::ALU_J : mips_id_pkg::ALU_JAL;
				dec.wreg = (opcode == mips_id_pkg::OPCODE_JAL);
				dec.wd = mips_id_pkg::LINK_REG;
				dec.reg1_read = 1'b0;
				dec.imm = imm_jidx;
			end
			mips_id_pkg::OPCODE_BEQ, mips_id_pkg::OPCODE_BNE: begin
				op = (opcode == mips_id_pkg::OPCODE_BEQ) ? mips_id_pkg::ALU_BEQ : mips_id_pkg::ALU_BNE;
				dec.wreg = 1'b0;
				dec.reg2_read = 1'b1;
				dec.imm = imm_boff;
			end
			mips_id_pkg::OPCODE_BLEZ, mips_id_pkg::OPCODE_BGTZ: begin
				op = (opcode == mips_id_pkg::OPCODE_BLEZ) ? mips_id_pkg::ALU_BLEZ :
					mips_id_pkg::ALU_BGTZ;
				dec.wreg = 1'b0;
				dec.imm = imm_boff;
			end
			mips_id_pkg::OPCODE_REGIMM: begin
				// and-link forms put pc+8 into r31
				dec.wreg = (rt == mips_id_pkg::REGIMM_BGEZAL) || (rt == mips_id_pkg::REGIMM_BLTZAL);
				dec.wd = mips_id_pkg::LINK_REG;
				dec.imm = imm_boff;
				case (rt)
					mips_id_pkg::REGIMM_BLTZ: op = mips_id_pkg::ALU_BLTZ;
					mips_id_pkg::REGIMM_BGEZ: op = mips_id_pkg::ALU_BGEZ;
					mips_id_pkg::REGIMM_BLTZAL: op = mips_id_pkg::ALU_BLTZAL;
					mips_id_pkg::REGIMM_BGEZAL: op = mips_id_pkg::ALU_BGEZAL;
					default: op = mips_id_pkg::ALU_NOP;
				endcase
			end
			default: op = mips_id_pkg::ALU_NOP;
		endcase
		// anything not recognised leaves as a plain nop
		if (op == mips_id_pkg::ALU_NOP) begin
			dec.wreg = 1'b0;
			dec.reg1_read = 1'b0;
			dec.reg2_read = 1'b0;
			dec.imm = '0;
		end
	end

	assign dec.aluop = op;

	// result class, branch kind and link all follow from the op
	always_comb begin
		dec.alusel = mips_id_pkg::SEL_JUMP_BRANCH;
		dec.branch_kind = mips_id_pkg::BR_NONE;
		dec.link = 1'b0;
		case (op)
			mips_id_pkg::ALU_OR, mips_id_pkg::ALU_AND, mips_id_pkg::ALU_XOR,
			mips_id_pkg::ALU_NOR: dec.alusel = mips_id_pkg::SEL_LOGIC;
			mips_id_pkg::ALU_SLL, mips_id_pkg::ALU_SRL,
			mips_id_pkg::ALU_SRA: dec.alusel = mips_id_pkg::SEL_SHIFT;
			mips_id_pkg::ALU_ADD, mips_id_pkg::ALU_ADDU, mips_id_pkg::ALU_ADDI,
			mips_id_pkg::ALU_ADDIU, mips_id_pkg::ALU_SUB, mips_id_pkg::ALU_SUBU,
			mips_id_pkg::ALU_SLT, mips_id_pkg::ALU_SLTU: dec.alusel = mips_id_pkg::SEL_ARITH;
			mips_id_pkg::ALU_LB, mips_id_pkg::ALU_LBU, mips_id_pkg::ALU_LH, mips_id_pkg::ALU_LHU,
			mips_id_pkg::ALU_LW, mips_id_pkg::ALU_SB, mips_id_pkg::ALU_SH,
			mips_id_pkg::ALU_SW: dec.alusel = mips_id_pkg::SEL_LOAD_STORE;
			mips_id_pkg::ALU_J: dec.branch_kind = mips_id_pkg::BR_JUMP_IMM;
			mips_id_pkg::ALU_JR: dec.branch_kind = mips_id_pkg::BR_JUMP_REG;
			mips_id_pkg::ALU_BEQ: dec.branch_kind = mips_id_pkg::BR_EQ;
			mips_id_pkg::ALU_BNE: dec.branch_kind = mips_id_pkg::BR_NE;
			mips_id_pkg::ALU_BGTZ: dec.branch_kind = mips_id_pkg::BR_GTZ;
			mips_id_pkg::ALU_BLEZ: dec.branch_kind = mips_id_pkg::BR_LEZ;
			mips_id_pkg::ALU_BGEZ: dec.branch_kind = mips_id_pkg::BR_GEZ;
			mips_id_pkg::ALU_BLTZ: dec.branch_kind = mips_id_pkg::BR_LTZ;
			mips_id_pkg::ALU_JAL: begin
				dec.branch_kind = mips_id_pkg::BR_JUMP_IMM;
				dec.link = 1'b1;
			end
			mips_id_pkg::ALU_JALR: begin
				dec.branch_kind = mips_id_pkg::BR_JUMP_REG;
				dec.link = 1'b1;
			end
			mips_id_pkg::ALU_BGEZAL: begin
				dec.branch_kind = mips_id_pkg::BR_GEZ;
				dec.link = 1'b1;
			end
			mips_id_pkg::ALU_BLTZAL: begin
				dec.branch_kind = mips_id_pkg::BR_LTZ;
				dec.link = 1'b1;
			end
			default: dec.alusel = mips_id_pkg::SEL_NOP;
		endcase
	end

endmodule

/* hw/id_operand_mux.sv */
`timescale 1ns/100ps

module id_operand_mux (
	id_decode_if.operand        dec,
	id_fwd_if.mux               fwd,
	input  logic                sel_rt_i,
	input  mips_id_pkg::word_t  rf_data_i,
	output mips_id_pkg::word_t  val_o,
	output logic                stall_o
);

	logic rd_en;
	mips_id_pkg::reg_addr_t rd_addr;
	logic ex_is_load;

	// port 1 reads rs, port 2 reads rt
	assign rd_en = sel_rt_i ? dec.reg2_read : dec.reg1_read;
	assign rd_addr = sel_rt_i ? dec.reg2_addr : dec.reg1_addr;

	// load data only shows up in MEM, too late to forward from EX
	always_comb begin
		case (fwd.ex_aluop)
			mips_id_pkg::ALU_LB, mips_id_pkg::ALU_LBU, mips_id_pkg::ALU_LH,
			mips_id_pkg::ALU_LHU, mips_id_pkg::ALU_LW: ex_is_load = 1'b1;
			default: ex_is_load = 1'b0;
		endcase
	end

	// youngest producer wins
	always_comb begin
		stall_o = 1'b0;
		val_o = '0;
		if (!rd_en)
			val_o = dec.imm;
		else if (ex_is_load && fwd.ex_wreg && fwd.ex_wd == rd_addr)
			stall_o = 1'b1;
		else if (fwd.ex_wreg && fwd.ex_wd == rd_addr)
			val_o = fwd.ex_wdata;
		else if (fwd.mem_wreg && fwd.mem_wd == rd_addr)
			val_o = fwd.mem_wdata;
		else
			val_o = rf_data_i;
	end

endmodule

/* hw/id_branch_unit.sv */
`timescale 1ns/100ps

module id_branch_unit (
	input  mips_id_pkg::word_t  pc_i,
	id_decode_if.branch         dec,
	input  mips_id_pkg::word_t  reg1_i,
	input  mips_id_pkg::word_t  reg2_i,
	input  logic                stall_i,
	output logic                branch_flag_o,
	output mips_id_pkg::word_t  branch_target_o,
	output mips_id_pkg::word_t  link_addr_o
);

	mips_id_pkg::word_t pc_plus_4;
	mips_id_pkg::word_t pc_plus_8;
	logic taken;

	assign pc_plus_4 = pc_i + 32'd4;
	// skip the delay slot on return
	assign pc_plus_8 = pc_i + 32'd8;

	// condition on the forwarded operands
	always_comb begin
		case (dec.branch_kind)
			mips_id_pkg::BR_JUMP_IMM, mips_id_pkg::BR_JUMP_REG: taken = 1'b1;
			mips_id_pkg::BR_EQ: taken = (reg1_i == reg2_i);
			mips_id_pkg::BR_NE: taken = (reg1_i != reg2_i);
			mips_id_pkg::BR_GTZ: taken = ($signed(reg1_i) > 32'sd0);
			mips_id_pkg::BR_LEZ: taken = ($signed(reg1_i) <= 32'sd0);
			mips_id_pkg::BR_GEZ: taken = ($signed(reg1_i) >= 32'sd0);
			mips_id_pkg::BR_LTZ: taken = ($signed(reg1_i) < 32'sd0);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (dec.branch_kind)
			mips_id_pkg::BR_NONE: branch_target_o = '0;
			// 256MB region of the delay slot
			mips_id_pkg::BR_JUMP_IMM: branch_target_o = {pc_plus_4[31:28], dec.imm[27:0]};
			mips_id_pkg::BR_JUMP_REG: branch_target_o = reg1_i;
			default: branch_target_o = pc_plus_4 + dec.imm;
		endcase
	end

	// operands are not valid yet during a load-use stall
	assign branch_flag_o = taken && !stall_i;
	assign link_addr_o = dec.link ? pc_plus_8 : '0;

endmodule

/* hw/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    stall_i,
	id_decode_if.pipe               dec,
	input  mips_id_pkg::word_t      reg1_i,
	input  mips_id_pkg::word_t      reg2_i,
	input  mips_id_pkg::word_t      link_addr_i,
	output mips_id_pkg::aluop_t     ex_aluop_o,
	output mips_id_pkg::alusel_t    ex_alusel_o,
	output mips_id_pkg::word_t      ex_reg1_o,
	output mips_id_pkg::word_t      ex_reg2_o,
	output mips_id_pkg::reg_addr_t  ex_wd_o,
	output logic                    ex_wreg_o,
	output mips_id_pkg::word_t      ex_link_addr_o
);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_aluop_o <= mips_id_pkg::ALU_NOP;
			ex_alusel_o <= mips_id_pkg::SEL_NOP;
			ex_wreg_o <= 1'b0;
			ex_wd_o <= mips_id_pkg::NOP_REG;
			ex_reg1_o <= '0;
			ex_reg2_o <= '0;
			ex_link_addr_o <= '0;
		end else if (stall_i) begin
			// bubble, the held instruction goes again next cycle
			ex_aluop_o <= mips_id_pkg::ALU_NOP;
			ex_alusel_o <= mips_id_pkg::SEL_NOP;
			ex_wreg_o <= 1'b0;
			ex_wd_o <= mips_id_pkg::NOP_REG;
			ex_reg1_o <= '0;
			ex_reg2_o <= '0;
			ex_link_addr_o <= '0;
		end else begin
			ex_aluop_o <= dec.aluop;
			ex_alusel_o <= dec.alusel;
			ex_wreg_o <= dec.wreg;
			ex_wd_o <= dec.wd;
			ex_reg1_o <= reg1_i;
			ex_reg2_o <= reg2_i;
			ex_link_addr_o <= link_addr_i;
		end
	end

endmodule

/* hw/id_stage_top.sv */
`timescale 1ns/100ps

module id_stage_top (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  mips_id_pkg::word_t      pc_i,
	input  mips_id_pkg::word_t      inst_i,
	input  mips_id_pkg::word_t      reg1_data_i,
	input  mips_id_pkg::word_t      reg2_data_i,
	input  logic                    ex_wreg_i,
	input  mips_id_pkg::reg_addr_t  ex_wd_i,
	input  mips_id_pkg::word_t      ex_wdata_i,
	input  mips_id_pkg::aluop_t     ex_aluop_i,
	input  logic                    mem_wreg_i,
	input  mips_id_pkg::reg_addr_t  mem_wd_i,
	input  mips_id_pkg::word_t      mem_wdata_i,
	output logic                    reg1_read_o,
	output mips_id_pkg::reg_addr_t  reg1_addr_o,
	output logic                    reg2_read_o,
	output mips_id_pkg::reg_addr_t  reg2_addr_o,
	output logic                    stallreq_o,
	output logic                    branch_flag_o,
	output mips_id_pkg::word_t      branch_target_o,
	output mips_id_pkg::aluop_t     ex_aluop_o,
	output mips_id_pkg::alusel_t    ex_alusel_o,
	output mips_id_pkg::word_t      ex_reg1_o,
	output mips_id_pkg::word_t      ex_reg2_o,
	output mips_id_pkg::reg_addr_t  ex_wd_o,
	output logic                    ex_wreg_o,
	output mips_id_pkg::word_t      ex_link_addr_o
);

	id_decode_if dec_if ();
	id_fwd_if fwd_if ();

	mips_id_pkg::word_t reg1_val;
	mips_id_pkg::word_t reg2_val;
	mips_id_pkg::word_t link_addr;
	logic reg1_stall;
	logic reg2_stall;

	// forwarding sources from later stages
	assign fwd_if.ex_wreg = ex_wreg_i;
	assign fwd_if.ex_wd = ex_wd_i;
	assign fwd_if.ex_wdata = ex_wdata_i;
	assign fwd_if.ex_aluop = ex_aluop_i;
	assign fwd_if.mem_wreg = mem_wreg_i;
	assign fwd_if.mem_wd = mem_wd_i;
	assign fwd_if.mem_wdata = mem_wdata_i;

	// regfile answers in the same cycle
	assign reg1_read_o = dec_if.reg1_read;
	assign reg1_addr_o = dec_if.reg1_addr;
	assign reg2_read_o = dec_if.reg2_read;
	assign reg2_addr_o = dec_if.reg2_addr;

	assign stallreq_o = reg1_stall | reg2_stall;

	id_decoder i_id_decoder (
		.inst_i (inst_i),
		.dec    (dec_if)
	);

	id_operand_mux i_reg1_mux (
		.dec       (dec_if),
		.fwd       (fwd_if),
		.sel_rt_i  (1'b0),
		.rf_data_i (reg1_data_i),
		.val_o     (reg1_val),
		.stall_o   (reg1_stall)
	);

	id_operand_mux i_reg2_mux (
		.dec       (dec_if),
		.fwd       (fwd_if),
		.sel_rt_i  (1'b1),
		.rf_data_i (reg2_data_i),
		.val_o     (reg2_val),
		.stall_o   (reg2_stall)
	);

	id_branch_unit i_id_branch_unit (
		.pc_i            (pc_i),
		.dec             (dec_if),
		.reg1_i          (reg1_val),
		.reg2_i          (reg2_val),
		.stall_i         (stallreq_o),
		.branch_flag_o   (branch_flag_o),
		.branch_target_o (branch_target_o),
		.link_addr_o     (link_addr)
	);

	id_ex_reg i_id_ex_reg (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.stall_i        (stallreq_o),
		.dec            (dec_if),
		.reg1_i         (reg1_val),
		.reg2_i         (reg2_val),
		.link_addr_i    (link_addr),
		.ex_aluop_o     (ex_aluop_o),
		.ex_alusel_o    (ex_alusel_o),
		.ex_reg1_o      (ex_reg1_o),
		.ex_reg2_o      (ex_reg2_o),
		.ex_wd_o        (ex_wd_o),
		.ex_wreg_o      (ex_wreg_o),
		.ex_link_addr_o (ex_link_addr_o)
	);

endmodule

/* sim/id_stage_chk.sv */
`timescale 1ns/100ps

module id_stage_chk (
	input logic                    clk,
	input logic                    arst_n_i,
	input logic                    stall_i,
	input logic                    flag_i,
	input logic                    wreg_i,
	input mips_id_pkg::reg_addr_t  wd_i,
	input mips_id_pkg::aluop_t     aluop_i
);

	logic is_link;

	// ops in EX that write a return address
	assign is_link = (aluop_i == mips_id_pkg::ALU_JAL) || (aluop_i == mips_id_pkg::ALU_JALR) ||
		(aluop_i == mips_id_pkg::ALU_BGEZAL) || (aluop_i == mips_id_pkg::ALU_BLTZAL);

	// stall turns into a bubble at the next edge
	stall_gives_bubble: assert property (@(posedge clk) disable iff (!arst_n_i)
		stall_i |=> !wreg_i)
		else $error("ex_wreg_o high in the cycle after a stall request");

	no_branch_in_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(flag_i && stall_i))
		else $error("branch_flag_o high while stallreq_o is high");

	// return address never lands in r0
	link_not_r0: assert property (@(posedge clk) disable iff (!arst_n_i)
		(wreg_i && is_link) |-> (wd_i != mips_id_pkg::NOP_REG))
		else $error("link instruction writes r0");

endmodule

bind id_stage_top id_stage_chk i_id_stage_chk (
	.clk      (clk),
	.arst_n_i (arst_n_i),
	.stall_i  (stallreq_o),
	.flag_i   (branch_flag_o),
	.wreg_i   (ex_wreg_o),
	.wd_i     (ex_wd_o),
	.aluop_i  (ex_aluop_o)
);

/* sim/id_stage_tb.sv */
`timescale 1ns/100ps

module id_stage_tb;

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 4;
	localparam int WATCHDOG_CYCLES = 400;
	localparam int NUM_COLS = 25;

	logic clk;
	logic arst_n_i;
	mips_id_pkg::word_t pc_i;
	mips_id_pkg::word_t inst_i;
	mips_id_pkg::word_t reg1_data_i;
	mips_id_pkg::word_t reg2_data_i;
	logic ex_wreg_i;
	mips_id_pkg::reg_addr_t ex_wd_i;
	mips_id_pkg::word_t ex_wdata_i;
	mips_id_pkg::aluop_t ex_aluop_i;
	logic mem_wreg_i;
	mips_id_pkg::reg_addr_t mem_wd_i;
	mips_id_pkg::word_t mem_wdata_i;
	logic reg1_read_o;
	mips_id_pkg::reg_addr_t reg1_addr_o;
	logic reg2_read_o;
	mips_id_pkg::reg_addr_t reg2_addr_o;
	logic stallreq_o;
	logic branch_flag_o;
	mips_id_pkg::word_t branch_target_o;
	mips_id_pkg::aluop_t ex_aluop_o;
	mips_id_pkg::alusel_t ex_alusel_o;
	mips_id_pkg::word_t ex_reg1_o;
	mips_id_pkg::word_t ex_reg2_o;
	mips_id_pkg::reg_addr_t ex_wd_o;
	logic ex_wreg_o;
	mips_id_pkg::word_t ex_link_addr_o;

	// one parsed line of the case file
	logic [31:0] col [NUM_COLS];
	int n_cases;

	id_stage_top i_id_stage_top (.*);

	initial clk = 1'b0;
	always #HALF_PERIOD clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input mips_id_pkg::word_t got,
			input mips_id_pkg::word_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns, case %0d: %s is %h, expected %h",
				$time, n_cases, name, got, exp));
	endtask

	task automatic check_addr(input string name, input mips_id_pkg::reg_addr_t got,
			input mips_id_pkg::reg_addr_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns, case %0d: %s is %h, expected %h",
				$time, n_cases, name, got, exp));
	endtask

	task automatic check_aluop(input string name, input mips_id_pkg::aluop_t got,
			input mips_id_pkg::aluop_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns, case %0d: %s is %h, expected %h",
				$time, n_cases, name, got, exp));
	endtask

	task automatic check_alusel(input string name, input mips_id_pkg::alusel_t got,
			input mips_id_pkg::alusel_t exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns, case %0d: %s is %h, expected %h",
				$time, n_cases, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns, case %0d: %s is %b, expected %b",
				$time, n_cases, name, got, exp));
	endtask

	// stimulus sits in columns 0..10
	task automatic apply_case();
		pc_i = col[0];
		inst_i = col[1];
		reg1_data_i = col[2];
		reg2_data_i = col[3];
		ex_wreg_i = col[4][0];
		ex_wd_i = col[5][4:0];
		ex_wdata_i = col[6];
		ex_aluop_i = mips_id_pkg::aluop_t'(col[7][7:0]);
		mem_wreg_i = col[8][0];
		mem_wd_i = col[9][4:0];
		mem_wdata_i = col[10];
	endtask

	// columns 11..17 hold in the stimulus cycle
	task automatic check_comb_outputs();
		check_bit("reg1_read_o", reg1_read_o, col[11][0]);
		check_addr("reg1_addr_o", reg1_addr_o, col[12][4:0]);
		check_bit("reg2_read_o", reg2_read_o, col[13][0]);
		check_addr("reg2_addr_o", reg2_addr_o, col[14][4:0]);
		check_bit("stallreq_o", stallreq_o, col[15][0]);
		check_bit("branch_flag_o", branch_flag_o, col[16][0]);
		check_word("branch_target_o", branch_target_o, col[17]);
	endtask

	// columns 18..24 hold one rising edge later
	task automatic check_ex_outputs();
		check_aluop("ex_aluop_o", ex_aluop_o, mips_id_pkg::aluop_t'(col[18][7:0]));
		check_alusel("ex_alusel_o", ex_alusel_o, mips_id_pkg::alusel_t'(col[19][2:0]));
		check_word("ex_reg1_o", ex_reg1_o, col[20]);
		check_word("ex_reg2_o", ex_reg2_o, col[21]);
		check_addr("ex_wd_o", ex_wd_o, col[22][4:0]);
		check_bit("ex_wreg_o", ex_wreg_o, col[23][0]);
		check_word("ex_link_addr_o", ex_link_addr_o, col[24]);
	endtask

	// delay based so a dead clock is caught too
	initial begin
		for (int c = 0; c < WATCHDOG_CYCLES; c++)
			#(2 * HALF_PERIOD);
		fail_run("simulation ran past its cycle limit without finishing");
	end

	initial begin
		int fd;
		int n;
		string line;
		n_cases = 0;
		arst_n_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		reg1_data_i = '0;
		reg2_data_i = '0;
		ex_wreg_i = 1'b0;
		ex_wd_i = '0;
		ex_wdata_i = '0;
		ex_aluop_i = mips_id_pkg::ALU_NOP;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;

		// ID/EX must come out of reset holding a bubble
		check_bit("ex_wreg_o", ex_wreg_o, 1'b0);
		check_aluop("ex_aluop_o", ex_aluop_o, mips_id_pkg::ALU_NOP);
		check_alusel("ex_alusel_o", ex_alusel_o, mips_id_pkg::SEL_NOP);
		check_addr("ex_wd_o", ex_wd_o, mips_id_pkg::NOP_REG);
		check_word("ex_reg1_o", ex_reg1_o, '0);
		check_word("ex_reg2_o", ex_reg2_o, '0);
		check_word("ex_link_addr_o", ex_link_addr_o, '0);

		fd = $fopen("sim/id_stage_cases.txt", "r");
		if (fd == 0)
			fail_run("could not open the case file sim/id_stage_cases.txt");
		while ($fgets(line, fd) != 0) begin
			// skip comments and blank lines
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14],
					col[15], col[16], col[17], col[18], col[19], col[20], col[21],
					col[22], col[23], col[24]);
				if (n != NUM_COLS)
					fail_run($sformatf("case file line has %0d fields: %s", n, line));
				n_cases++;
				apply_case();
				// let the decode settle mid low phase
				#(HALF_PERIOD / 2);
				check_comb_outputs();
				@(negedge clk);
				check_ex_outputs();
			end
		end
		$fclose(fd);

		if (n_cases == 0) begin
			fail_run("the case file held no cases");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

/* sim/id_stage_cases.txt */
# in (hex): pc inst rf1 rf2 ex_wreg ex_wd ex_wdata ex_aluop mem_wreg mem_wd mem_wdata
# expected: rd1 a1 rd2 a2 stall bflag btarget, then aluop alusel reg1 reg2 wd wreg link
# unknown opcode
400 fc430000 1a 2b  0 0 0 0 0 0 0  0 2 0 3 0 0 0  00 0 0 0 3 0 0
# alu decode, register and immediate forms
400 34228001 1a 2b  0 0 0 0 0 0 0  1 1 0 2 0 0 0  25 1 1a 8001 2 1 0
400 3c02abcd 0 2b  0 0 0 0 0 0 0  1 0 0 2 0 0 0  25 1 0 abcd0000 2 1 0
400 2022fffc 1a 2b  0 0 0 0 0 0 0  1 1 0 2 0 0 0  55 4 1a fffffffc 2 1 0
400 00221821 1a 2b  0 0 0 0 0 0 0  1 1 1 2 0 0 0  21 4 1a 2b 3 1 0
400 00021943 1a 2b  0 0 0 0 0 0 0  0 0 1 2 0 0 0  03 2 5 2b 3 1 0
400 ac220008 1a 2b  0 0 0 0 0 0 0  1 1 1 2 0 0 0  eb 7 1a 2b 2 0 0
400 8c22fff8 1a 2b  0 0 0 0 0 0 0  1 1 0 2 0 0 0  e3 7 1a fffffff8 2 1 0
# forwarding priority
400 00221821 1a 2b  1 1 111 21 1 1 222  1 1 1 2 0 0 0  21 4 111 2b 3 1 0
400 00221821 1a 2b  1 5 111 21 1 2 333  1 1 1 2 0 0 0  21 4 1a 333 3 1 0
400 00221821 1a 2b  0 1 111 21 0 2 333  1 1 1 2 0 0 0  21 4 1a 2b 3 1 0
# load-use stall, then the load sits in MEM
400 00221821 1a 2b  1 2 444 e3 0 0 0  1 1 1 2 1 0 0  00 0 0 0 0 0 0
400 00221821 1a 2b  0 0 0 0 1 2 555  1 1 1 2 0 0 0  21 4 1a 555 3 1 0
# branches and jumps
1000 10220004 7 7  0 0 0 0 0 0 0  1 1 1 2 0 1 1014  51 6 7 7 2 0 0
1000 1422fffe 7 7  0 0 0 0 0 0 0  1 1 1 2 0 0 ffc  52 6 7 7 2 0 0
1000 1c200008 ffffffff 2b  0 0 0 0 0 0 0  1 1 0 0 0 0 1024  54 6 ffffffff 20 0 0 0
1000 18200008 0 2b  0 0 0 0 0 0 0  1 1 0 0 0 1 1024  53 6 0 20 0 0 0
1000 04200008 80000000 2b  0 0 0 0 0 0 0  1 1 0 0 0 1 1024  40 6 80000000 20 1f 0 0
1000 04310008 0 2b  0 0 0 0 0 0 0  1 1 0 11 0 1 1024  4b 6 0 20 1f 1 1008
30001000 08123456 1a 2b  0 0 0 0 0 0 0  0 0 0 12 0 1 3048d158  4f 6 48d158 48d158 1f 0 0
400 0c000040 1a 2b  0 0 0 0 0 0 0  0 0 0 0 0 1 100  50 6 100 100 1f 1 408
400 00200008 1a 2b  1 1 2000 21 0 0 0  1 1 0 0 0 1 2000  08 6 2000 0 0 0 0
400 0020f809 3000 2b  0 0 0 0 0 0 0  1 1 0 0 0 1 3000  09 6 3000 0 1f 1 408
# branch held by a load-use stall, then resolved from MEM
1000 10220004 7 7  1 1 0 e3 0 0 0  1 1 1 2 1 0 1014  00 0 0 0 0 0 0
1000 10220004 0 7  0 0 0 0 1 1 7  1 1 1 2 0 1 1014  51 6 7 7 2 0 0

/* project.f */
hw/mips_id_pkg.sv
hw/id_bus_if.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage_top.sv
sim/id_stage_chk.sv
sim/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f project.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/id_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi
exit 0
